// ==== cpu_consts.svh ====
`ifndef CPU_CONSTS_SVH
`define CPU_CONSTS_SVH

// Primary opcodes, instr[31:26]
`define OP_SPECIAL 6'h00 // R-type, decode by function field
`define OP_J       6'h02
`define OP_JAL     6'h03
`define OP_BEQ     6'h04
`define OP_ORI     6'h0d
`define OP_LUI     6'h0f
`define OP_LW      6'h23
`define OP_SW      6'h2b

// Function codes, instr[5:0]
`define FN_SLL     6'h00
`define FN_JR      6'h08
`define FN_ADDU    6'h21
`define FN_SUBU    6'h23

/////////////////////////////
// Pipeline timing codes
`define TUSE_NONE  3'd7 // Source never read
`define TNEW_NONE  3'd0 // No GPR result

`define RESET_PC   32'h0000_3000 // First fetch address

// Operand source selects
`define FWD_REG    2'd0 // Register file read
`define FWD_EX     2'd1 // Registered ID/EX result
`define FWD_MEM    2'd2 // Memory stage result

`define LINK_REG   5'd31 // jal return address

`endif

// ==== cpuPkg.sv ====
package cpuPkg;

	typedef logic [31:0] word_t; // Data word or byte address
	typedef logic [4:0] regAddr_t; // GPR number
	typedef logic [2:0] timing_t; // Cycles until use or result, 7 never used
	typedef logic [1:0] fwdSel_t; // Operand source for one decode read

	// Decoded instruction, one per supported opcode
	typedef enum logic [3:0]
	{
		kindNop, // Also any unknown encoding
		kindAddu,
		kindSubu,
		kindOri,
		kindLui,
		kindLw,
		kindSw,
		kindBeq,
		kindJ,
		kindJal,
		kindJr,
		kindSll
	} instrKind_t;

endpackage

// ==== instrDecoder.sv ====
`include "cpu_consts.svh"

module instrDecoder
(
	input cpuPkg::word_t instr,
	output cpuPkg::instrKind_t kind,
	output cpuPkg::regAddr_t rs,
	output cpuPkg::regAddr_t rt,
	output cpuPkg::regAddr_t dest,
	output logic [4:0] shamt,
	output cpuPkg::word_t imm,
	output cpuPkg::timing_t tuseRs,
	output cpuPkg::timing_t tuseRt,
	output cpuPkg::timing_t tnew
);

	logic [5:0] opcode;
	logic [5:0] funct;
	cpuPkg::regAddr_t rsField;
	cpuPkg::regAddr_t rtField;
	cpuPkg::regAddr_t rdField;

	assign opcode = instr[31:26];
	assign funct = instr[5:0];
	assign rsField = instr[25:21];
	assign rtField = instr[20:16];
	assign rdField = instr[15:11];

	//////////////////////////////
	// Instruction kind
	always_comb
	begin
		kind = cpuPkg::kindNop; // Unknown encodings fall back here
		case (opcode)
			`OP_SPECIAL:
			begin
				case (funct)
					`FN_ADDU: kind = cpuPkg::kindAddu;
					`FN_SUBU: kind = cpuPkg::kindSubu;
					`FN_JR: kind = cpuPkg::kindJr;
					`FN_SLL:
					begin
						if (instr != 32'd0) // All-zero word is the canonical nop
							kind = cpuPkg::kindSll;
					end
					default: kind = cpuPkg::kindNop;
				endcase
			end
			`OP_ORI: kind = cpuPkg::kindOri;
			`OP_LUI: kind = cpuPkg::kindLui;
			`OP_LW: kind = cpuPkg::kindLw;
			`OP_SW: kind = cpuPkg::kindSw;
			`OP_BEQ: kind = cpuPkg::kindBeq;
			`OP_J: kind = cpuPkg::kindJ;
			`OP_JAL: kind = cpuPkg::kindJal;
			default: kind = cpuPkg::kindNop;
		endcase
	end

	// Extender folded in, ori is the only zero-extended form
	assign imm = (kind == cpuPkg::kindOri) ? {16'd0, instr[15:0]} :
		{{16{instr[15]}}, instr[15:0]};
	assign shamt = (kind == cpuPkg::kindSll) ? instr[10:6] : 5'd0;

	//////////////////////////////
	// Destination and use/new timing
	always_comb
	begin
		tuseRs = `TUSE_NONE;
		tuseRt = `TUSE_NONE;
		tnew = `TNEW_NONE;
		dest = 5'd0; // No GPR write by default
		case (kind)
			cpuPkg::kindAddu, cpuPkg::kindSubu:
			begin
				tuseRs = 3'd1;
				tuseRt = 3'd1;
				tnew = 3'd1;
				dest = rdField;
			end
			cpuPkg::kindSll:
			begin
				tuseRt = 3'd1; // rs slot carries shamt instead
				tnew = 3'd1;
				dest = rdField;
			end
			cpuPkg::kindOri:
			begin
				tuseRs = 3'd1;
				tnew = 3'd1;
				dest = rtField;
			end
			cpuPkg::kindLui:
			begin
				tnew = 3'd0; // Value formed in decode
				dest = rtField;
			end
			cpuPkg::kindLw:
			begin
				tuseRs = 3'd1; // Address add in execute
				tnew = 3'd2;
				dest = rtField;
			end
			cpuPkg::kindSw:
			begin
				tuseRs = 3'd1;
				tuseRt = 3'd2; // Store data needed in memory stage
			end
			cpuPkg::kindBeq:
			begin
				tuseRs = 3'd0; // Compare in decode
				tuseRt = 3'd0;
			end
			cpuPkg::kindJr: tuseRs = 3'd0;
			cpuPkg::kindJal:
			begin
				tnew = 3'd0; // Link value formed in decode
				dest = `LINK_REG;
			end
			default: dest = 5'd0;
		endcase
	end

	// Unused sources read as r0 so they never match a producer
	assign rs = (tuseRs == `TUSE_NONE) ? 5'd0 : rsField;
	assign rt = (tuseRt == `TUSE_NONE) ? 5'd0 : rtField;

endmodule

// ==== regFile.sv ====
module regFile
(
	input logic clk,
	input logic rst,
	input cpuPkg::regAddr_t rdAddr0,
	input cpuPkg::regAddr_t rdAddr1,
	output cpuPkg::word_t rdData0,
	output cpuPkg::word_t rdData1,
	input cpuPkg::regAddr_t wrAddr, // r0 means no write
	input cpuPkg::word_t wrData
);

	cpuPkg::word_t regs [32];

	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'd0;
		end
		else if (wrAddr != 5'd0)
		begin
			regs[wrAddr] <= wrData;
		end
	end

	// Write-through so writeback and decode share a cycle
	assign rdData0 = (rdAddr0 == 5'd0) ? 32'd0 :
		(rdAddr0 == wrAddr) ? wrData : regs[rdAddr0];
	assign rdData1 = (rdAddr1 == 5'd0) ? 32'd0 :
		(rdAddr1 == wrAddr) ? wrData : regs[rdAddr1];

endmodule

// ==== hazardUnit.sv ====
`include "cpu_consts.svh"

module hazardUnit
(
	input cpuPkg::regAddr_t rs,
	input cpuPkg::regAddr_t rt,
	input cpuPkg::timing_t tuseRs,
	input cpuPkg::timing_t tuseRt,
	input cpuPkg::regAddr_t exDest,
	input cpuPkg::timing_t exTnew,
	input logic exValid,
	input cpuPkg::regAddr_t memDest,
	input cpuPkg::timing_t memTnew,
	output logic stall,
	output cpuPkg::fwdSel_t fwdRs,
	output cpuPkg::fwdSel_t fwdRt
);

	// Producer not ready by the time this source is read
	function automatic logic needStall(input cpuPkg::regAddr_t src, input cpuPkg::timing_t tuse,
		input cpuPkg::regAddr_t exD, input cpuPkg::timing_t exT, input logic exV,
		input cpuPkg::regAddr_t memD, input cpuPkg::timing_t memT);
		logic exHit;
		logic memHit;
		exHit = exV && (src == exD);
		memHit = (src == memD);
		needStall = (src != 5'd0) && (tuse != `TUSE_NONE) &&
			((exHit && (exT > tuse)) || (memHit && (memT > tuse)));
	endfunction

	// Youngest ready producer wins
	function automatic cpuPkg::fwdSel_t pickFwd(input cpuPkg::regAddr_t src,
		input cpuPkg::regAddr_t exD, input cpuPkg::timing_t exT, input logic exV,
		input cpuPkg::regAddr_t memD, input cpuPkg::timing_t memT);
		pickFwd = `FWD_REG;
		if (src != 5'd0)
		begin
			if (exV && (src == exD) && (exT == 3'd0))
				pickFwd = `FWD_EX; // lui/jal result already in ID/EX
			else if ((src == memD) && (memT == 3'd0))
				pickFwd = `FWD_MEM;
		end
	endfunction

	//////////////////////////////
	always_comb
	begin
		stall = needStall(rs, tuseRs, exDest, exTnew, exValid, memDest, memTnew) ||
			needStall(rt, tuseRt, exDest, exTnew, exValid, memDest, memTnew);
		fwdRs = pickFwd(rs, exDest, exTnew, exValid, memDest, memTnew);
		fwdRt = pickFwd(rt, exDest, exTnew, exValid, memDest, memTnew);
	end

endmodule

// ==== decodeStage.sv ====
`include "cpu_consts.svh"

module decodeStage
(
	input logic clk,
	input logic rst,
	input cpuPkg::word_t instr,
	input cpuPkg::word_t pc,
	input logic instrValid,
	input logic stall,
	input cpuPkg::fwdSel_t fwdRs,
	input cpuPkg::fwdSel_t fwdRt,
	input cpuPkg::word_t memResult,
	output cpuPkg::regAddr_t regRead0, // GPR read addresses
	output cpuPkg::regAddr_t regRead1,
	input cpuPkg::word_t rdData0,
	input cpuPkg::word_t rdData1,
	output cpuPkg::regAddr_t rs, // To hazard unit
	output cpuPkg::regAddr_t rt,
	output cpuPkg::timing_t tuseRs,
	output cpuPkg::timing_t tuseRt,
	output logic exValid, // ID/EX register
	output cpuPkg::instrKind_t exKind,
	output cpuPkg::regAddr_t exRs,
	output cpuPkg::regAddr_t exRt,
	output cpuPkg::regAddr_t exDest,
	output logic [4:0] exShamt,
	output cpuPkg::word_t exImm,
	output cpuPkg::word_t exRsData,
	output cpuPkg::word_t exRtData,
	output cpuPkg::word_t exResult,
	output cpuPkg::word_t exPc,
	output cpuPkg::timing_t exTnew,
	output logic branchTaken,
	output logic jumpTaken,
	output cpuPkg::word_t target
);

	cpuPkg::instrKind_t kind;
	cpuPkg::regAddr_t dest;
	logic [4:0] shamt;
	cpuPkg::word_t imm;
	cpuPkg::timing_t tnew;
	cpuPkg::word_t rsData; // Forwarded operands
	cpuPkg::word_t rtData;
	cpuPkg::word_t opA; // rs slot as sent to execute
	cpuPkg::word_t idResult;
	cpuPkg::word_t pcPlus4;
	logic accept;

	function automatic cpuPkg::word_t fwdMux(input cpuPkg::fwdSel_t sel,
		input cpuPkg::word_t regVal, input cpuPkg::word_t exVal, input cpuPkg::word_t memVal);
		case (sel)
			`FWD_EX: fwdMux = exVal;
			`FWD_MEM: fwdMux = memVal;
			default: fwdMux = regVal;
		endcase
	endfunction

	instrDecoder decoder
	(
		.instr(instr),
		.kind(kind),
		.rs(rs),
		.rt(rt),
		.dest(dest),
		.shamt(shamt),
		.imm(imm),
		.tuseRs(tuseRs),
		.tuseRt(tuseRt),
		.tnew(tnew)
	);

	assign regRead0 = rs;
	assign regRead1 = rt;
	assign accept = instrValid && !stall; // Handshake with fetch

	//////////////////////////////
	// Operand forwarding
	assign rsData = fwdMux(fwdRs, rdData0, exResult, memResult);
	assign rtData = fwdMux(fwdRt, rdData1, exResult, memResult);
	assign opA = (kind == cpuPkg::kindSll) ? {27'd0, shamt} : rsData; // sll shifts by shamt

	//////////////////////////////
	// Branch and jump, resolved here
	assign pcPlus4 = pc + 32'd4;
	assign branchTaken = accept && (kind == cpuPkg::kindBeq) && (rsData == rtData);
	assign jumpTaken = accept && ((kind == cpuPkg::kindJ) || (kind == cpuPkg::kindJal) ||
		(kind == cpuPkg::kindJr));

	always_comb
	begin
		case (kind)
			cpuPkg::kindBeq: target = pcPlus4 + {imm[29:0], 2'b00};
			cpuPkg::kindJ, cpuPkg::kindJal: target = {pc[31:28], instr[25:0], 2'b00};
			cpuPkg::kindJr: target = rsData;
			default: target = pcPlus4; // Fall through
		endcase
	end

	// Results known in decode
	assign idResult = (kind == cpuPkg::kindLui) ? {imm[15:0], 16'd0} :
		(kind == cpuPkg::kindJal) ? pc + 32'd8 : 32'd0;

	//////////////////////////////
	// ID/EX register
	always_ff @(posedge clk)
	begin
		if (rst || !accept)
		begin
			exValid <= 1'b0; // Bubble
			exKind <= cpuPkg::kindNop;
			exRs <= 5'd0;
			exRt <= 5'd0;
			exDest <= 5'd0;
			exShamt <= 5'd0;
			exImm <= 32'd0;
			exRsData <= 32'd0;
			exRtData <= 32'd0;
			exResult <= 32'd0;
			exPc <= `RESET_PC;
			exTnew <= `TNEW_NONE;
		end
		else
		begin
			exValid <= 1'b1;
			exKind <= kind;
			exRs <= rs;
			exRt <= rt;
			exDest <= dest;
			exShamt <= shamt;
			exImm <= imm;
			exRsData <= opA;
			exRtData <= rtData;
			exResult <= idResult;
			exPc <= pc;
			exTnew <= tnew;
		end
	end

endmodule

// ==== decodeTop.sv ====
module decodeTop
(
	input logic clk,
	input logic rst,
	input cpuPkg::word_t instr, // Fetch side
	input cpuPkg::word_t pc,
	input logic instrValid,
	output logic instrReady,
	input cpuPkg::regAddr_t wbAddr, // Writeback port
	input cpuPkg::word_t wbData,
	input cpuPkg::regAddr_t memDest, // Memory stage producer
	input cpuPkg::timing_t memTnew,
	input cpuPkg::word_t memResult,
	output logic exValid, // To execute
	output cpuPkg::instrKind_t exKind,
	output cpuPkg::regAddr_t exRs,
	output cpuPkg::regAddr_t exRt,
	output cpuPkg::regAddr_t exDest,
	output logic [4:0] exShamt,
	output cpuPkg::word_t exImm,
	output cpuPkg::word_t exRsData,
	output cpuPkg::word_t exRtData,
	output cpuPkg::word_t exResult,
	output cpuPkg::word_t exPc,
	output cpuPkg::timing_t exTnew,
	output logic branchTaken, // Back to fetch
	output logic jumpTaken,
	output cpuPkg::word_t target
);

	logic stall;
	cpuPkg::fwdSel_t fwdRs;
	cpuPkg::fwdSel_t fwdRt;
	cpuPkg::regAddr_t regRead0;
	cpuPkg::regAddr_t regRead1;
	cpuPkg::word_t rdData0;
	cpuPkg::word_t rdData1;
	cpuPkg::regAddr_t rs;
	cpuPkg::regAddr_t rt;
	cpuPkg::timing_t tuseRs;
	cpuPkg::timing_t tuseRt;

	assign instrReady = !stall;

	decodeStage stage
	(
		.clk(clk), .rst(rst), .instr(instr), .pc(pc), .instrValid(instrValid),
		.stall(stall), .fwdRs(fwdRs), .fwdRt(fwdRt), .memResult(memResult),
		.regRead0(regRead0), .regRead1(regRead1), .rdData0(rdData0), .rdData1(rdData1),
		.rs(rs), .rt(rt), .tuseRs(tuseRs), .tuseRt(tuseRt),
		.exValid(exValid), .exKind(exKind), .exRs(exRs), .exRt(exRt), .exDest(exDest),
		.exShamt(exShamt), .exImm(exImm), .exRsData(exRsData), .exRtData(exRtData),
		.exResult(exResult), .exPc(exPc), .exTnew(exTnew),
		.branchTaken(branchTaken), .jumpTaken(jumpTaken), .target(target)
	);

	regFile gpr
	(
		.clk(clk), .rst(rst),
		.rdAddr0(regRead0), .rdAddr1(regRead1), .rdData0(rdData0), .rdData1(rdData1),
		.wrAddr(wbAddr), .wrData(wbData)
	);

	hazardUnit hazard
	(
		.rs(rs), .rt(rt), .tuseRs(tuseRs), .tuseRt(tuseRt),
		.exDest(exDest), .exTnew(exTnew), .exValid(exValid),
		.memDest(memDest), .memTnew(memTnew),
		.stall(stall), .fwdRs(fwdRs), .fwdRt(fwdRt)
	);

endmodule

// ==== decodeTb.sv ====
`include "cpu_consts.svh"

module decodeTb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int numTests = 3000;
	localparam int resetCycles = 5;

	logic clk;
	logic rst;
	cpuPkg::word_t instr; // Fetch side
	cpuPkg::word_t pc;
	logic instrValid;
	logic instrReady;
	cpuPkg::regAddr_t wbAddr;
	cpuPkg::word_t wbData;
	cpuPkg::regAddr_t memDest;
	cpuPkg::timing_t memTnew;
	cpuPkg::word_t memResult;
	logic exValid; // ID/EX outputs
	cpuPkg::instrKind_t exKind;
	cpuPkg::regAddr_t exRs;
	cpuPkg::regAddr_t exRt;
	cpuPkg::regAddr_t exDest;
	logic [4:0] exShamt;
	cpuPkg::word_t exImm;
	cpuPkg::word_t exRsData;
	cpuPkg::word_t exRtData;
	cpuPkg::word_t exResult;
	cpuPkg::word_t exPc;
	cpuPkg::timing_t exTnew;
	logic branchTaken;
	logic jumpTaken;
	cpuPkg::word_t target;

	integer seed = 32'hc0bf_0d4b;
	logic holdInstr; // Fetch keeps a refused instruction

	//////////////////////////////
	// Reference model state
	cpuPkg::word_t mRegs [32];
	logic mExValid;
	cpuPkg::instrKind_t mExKind;
	cpuPkg::regAddr_t mExRs;
	cpuPkg::regAddr_t mExRt;
	cpuPkg::regAddr_t mExDest;
	logic [4:0] mExShamt;
	cpuPkg::word_t mExImm;
	cpuPkg::word_t mExRsData;
	cpuPkg::word_t mExRtData;
	cpuPkg::word_t mExResult;
	cpuPkg::word_t mExPc;
	cpuPkg::timing_t mExTnew;

	decodeTop dut
	(
		.clk(clk), .rst(rst), .instr(instr), .pc(pc), .instrValid(instrValid),
		.instrReady(instrReady), .wbAddr(wbAddr), .wbData(wbData),
		.memDest(memDest), .memTnew(memTnew), .memResult(memResult),
		.exValid(exValid), .exKind(exKind), .exRs(exRs), .exRt(exRt), .exDest(exDest),
		.exShamt(exShamt), .exImm(exImm), .exRsData(exRsData), .exRtData(exRtData),
		.exResult(exResult), .exPc(exPc), .exTnew(exTnew),
		.branchTaken(branchTaken), .jumpTaken(jumpTaken), .target(target)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	initial
	begin
		#((numTests + resetCycles + 10) * 100); // One cycle per test plus margin
		abortRun("Timeout: the test loop did not finish in time");
	end

	task automatic abortRun(input string reason);
		$display("%s", reason);
		$display("Something failed");
		$fatal(1);
	endtask

	task automatic checkWord(input string what, input cpuPkg::word_t got,
		input cpuPkg::word_t exp);
		if (got !== exp)
			abortRun($sformatf("[ERROR] %0t: %s is %h, expected %h", $time, what, got, exp));
	endtask

	task automatic checkAddr(input string what, input cpuPkg::regAddr_t got,
		input cpuPkg::regAddr_t exp);
		if (got !== exp)
			abortRun($sformatf("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic checkKind(input string what, input cpuPkg::instrKind_t got,
		input cpuPkg::instrKind_t exp);
		if (got !== exp)
			abortRun($sformatf("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic checkTiming(input string what, input cpuPkg::timing_t got,
		input cpuPkg::timing_t exp);
		if (got !== exp)
			abortRun($sformatf("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp));
	endtask

	task automatic checkBit(input string what, input logic got, input logic exp);
		if (got !== exp)
			abortRun($sformatf("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp));
	endtask

	//////////////////////////////
	// Stimulus
	function automatic cpuPkg::word_t randWord();
		randWord = $random(seed);
	endfunction

	function automatic cpuPkg::regAddr_t pickReg();
		cpuPkg::word_t w;
		w = $random(seed);
		if (w[5:3] == 3'd0)
			pickReg = `LINK_REG; // Lets a jal result feed later reads
		else
			pickReg = {2'b00, w[2:0]}; // Low registers keep dependencies frequent
	endfunction

	function automatic cpuPkg::word_t genInstr();
		cpuPkg::regAddr_t s;
		cpuPkg::regAddr_t t;
		cpuPkg::regAddr_t d;
		cpuPkg::word_t w;
		cpuPkg::word_t pick;
		s = pickReg();
		t = pickReg();
		d = pickReg();
		w = randWord();
		pick = randWord() % 13;
		case (pick)
			0: genInstr = {`OP_SPECIAL, s, t, d, 5'd0, `FN_ADDU};
			1: genInstr = {`OP_SPECIAL, s, t, d, 5'd0, `FN_SUBU};
			2: genInstr = {`OP_ORI, s, t, w[15:0]};
			3: genInstr = {`OP_LUI, 5'd0, t, w[15:0]};
			4: genInstr = {`OP_LW, s, t, w[15:0]};
			5: genInstr = {`OP_SW, s, t, w[15:0]};
			6: genInstr = {`OP_BEQ, s, (w[16] ? s : t), w[15:0]}; // Equal operands half the time
			7: genInstr = {`OP_J, w[25:0]};
			8: genInstr = {`OP_JAL, w[25:0]};
			9: genInstr = {`OP_SPECIAL, s, 15'd0, `FN_JR};
			10: genInstr = {`OP_SPECIAL, 5'd0, t, d, w[10:6], `FN_SLL};
			11: genInstr = 32'd0;
			default: genInstr = w[26] ? {6'h3f, w[25:0]} : {`OP_SPECIAL, w[25:6], 6'h3f};
		endcase
	endfunction

	task automatic driveRandom();
		cpuPkg::word_t w;
		w = randWord();
		if (!holdInstr)
		begin
			instrValid <= (w[2:0] != 3'd0); // Idle one cycle in eight
			instr <= genInstr();
			pc <= randWord() & 32'hffff_fffc;
		end
		wbAddr <= pickReg();
		wbData <= randWord();
		memDest <= pickReg();
		memTnew <= {1'b0, w[5:4]};
		memResult <= randWord();
	endtask

	//////////////////////////////
	// Model behavior
	task automatic setBubble();
		mExValid = 1'b0;
		mExKind = cpuPkg::kindNop;
		mExRs = 5'd0;
		mExRt = 5'd0;
		mExDest = 5'd0;
		mExShamt = 5'd0;
		mExImm = 32'd0;
		mExRsData = 32'd0;
		mExRtData = 32'd0;
		mExResult = 32'd0;
		mExPc = `RESET_PC;
		mExTnew = `TNEW_NONE;
	endtask

	task automatic decodeModel(input cpuPkg::word_t ins, output cpuPkg::instrKind_t k,
		output cpuPkg::timing_t uRs, output cpuPkg::timing_t uRt,
		output cpuPkg::timing_t tn, output cpuPkg::regAddr_t d);
		k = cpuPkg::kindNop;
		case (ins[31:26])
			`OP_SPECIAL:
			begin
				if (ins[5:0] == `FN_ADDU)
					k = cpuPkg::kindAddu;
				else if (ins[5:0] == `FN_SUBU)
					k = cpuPkg::kindSubu;
				else if (ins[5:0] == `FN_JR)
					k = cpuPkg::kindJr;
				else if (ins[5:0] == `FN_SLL && ins != 32'd0) // Zero word is nop
					k = cpuPkg::kindSll;
			end
			`OP_ORI: k = cpuPkg::kindOri;
			`OP_LUI: k = cpuPkg::kindLui;
			`OP_LW: k = cpuPkg::kindLw;
			`OP_SW: k = cpuPkg::kindSw;
			`OP_BEQ: k = cpuPkg::kindBeq;
			`OP_J: k = cpuPkg::kindJ;
			`OP_JAL: k = cpuPkg::kindJal;
			default: k = cpuPkg::kindNop;
		endcase
		// Tuse from decode
		uRs = (k == cpuPkg::kindBeq || k == cpuPkg::kindJr) ? 3'd0 :
			(k == cpuPkg::kindAddu || k == cpuPkg::kindSubu || k == cpuPkg::kindOri ||
			k == cpuPkg::kindLw || k == cpuPkg::kindSw) ? 3'd1 : `TUSE_NONE;
		uRt = (k == cpuPkg::kindBeq) ? 3'd0 : (k == cpuPkg::kindSw) ? 3'd2 :
			(k == cpuPkg::kindAddu || k == cpuPkg::kindSubu || k == cpuPkg::kindSll) ? 3'd1 :
			`TUSE_NONE;
		// Tnew at entry to execute
		tn = (k == cpuPkg::kindLw) ? 3'd2 :
			(k == cpuPkg::kindAddu || k == cpuPkg::kindSubu || k == cpuPkg::kindOri ||
			k == cpuPkg::kindSll) ? 3'd1 : `TNEW_NONE;
		d = (k == cpuPkg::kindAddu || k == cpuPkg::kindSubu || k == cpuPkg::kindSll) ?
			ins[15:11] : (k == cpuPkg::kindOri || k == cpuPkg::kindLui || k == cpuPkg::kindLw) ?
			ins[20:16] : (k == cpuPkg::kindJal) ? `LINK_REG : 5'd0;
	endtask

	function automatic cpuPkg::word_t readReg(input cpuPkg::regAddr_t a);
		if (a == 5'd0)
			readReg = 32'd0;
		else if (a == wbAddr)
			readReg = wbData; // Same-cycle writeback
		else
			readReg = mRegs[a];
	endfunction

	function automatic logic mustStall(input cpuPkg::regAddr_t a, input cpuPkg::timing_t u);
		mustStall = (a != 5'd0) && (u != `TUSE_NONE) &&
			((mExValid && a == mExDest && mExTnew > u) || (a == memDest && memTnew > u));
	endfunction

	function automatic cpuPkg::word_t operand(input cpuPkg::regAddr_t a);
		if (a != 5'd0 && mExValid && a == mExDest && mExTnew == 3'd0)
			operand = mExResult; // Execute stage first
		else if (a != 5'd0 && a == memDest && memTnew == 3'd0)
			operand = memResult;
		else
			operand = readReg(a);
	endfunction

	task automatic compareIdEx();
		checkBit("exValid", exValid, mExValid);
		checkKind("exKind", exKind, mExKind);
		checkAddr("exRs", exRs, mExRs);
		checkAddr("exRt", exRt, mExRt);
		checkAddr("exDest", exDest, mExDest);
		checkWord("exShamt", {27'd0, exShamt}, {27'd0, mExShamt});
		checkWord("exImm", exImm, mExImm);
		checkWord("exRsData", exRsData, mExRsData);
		checkWord("exRtData", exRtData, mExRtData);
		checkWord("exResult", exResult, mExResult);
		checkWord("exPc", exPc, mExPc);
		checkTiming("exTnew", exTnew, mExTnew);
	endtask

	task automatic evaluateCycle();
		cpuPkg::instrKind_t k;
		cpuPkg::timing_t uRs;
		cpuPkg::timing_t uRt;
		cpuPkg::timing_t tn;
		cpuPkg::regAddr_t d;
		cpuPkg::regAddr_t aRs;
		cpuPkg::regAddr_t aRt;
		cpuPkg::word_t imm;
		cpuPkg::word_t vRs;
		cpuPkg::word_t vRt;
		logic stallExp;
		logic accept;
		compareIdEx(); // Captured at the last edge
		decodeModel(instr, k, uRs, uRt, tn, d);
		aRs = (uRs == `TUSE_NONE) ? 5'd0 : instr[25:21];
		aRt = (uRt == `TUSE_NONE) ? 5'd0 : instr[20:16];
		imm = (k == cpuPkg::kindOri) ? {16'd0, instr[15:0]} : {{16{instr[15]}}, instr[15:0]};
		stallExp = mustStall(aRs, uRs) || mustStall(aRt, uRt);
		vRs = operand(aRs);
		vRt = operand(aRt);
		accept = instrValid && !stallExp;
		checkBit("instrReady", instrReady, !stallExp);
		checkBit("branchTaken", branchTaken, accept && k == cpuPkg::kindBeq && vRs == vRt);
		checkBit("jumpTaken", jumpTaken, accept && (k == cpuPkg::kindJ ||
			k == cpuPkg::kindJal || k == cpuPkg::kindJr));
		if (k == cpuPkg::kindBeq)
			checkWord("beq target", target, pc + 32'd4 + (imm << 2));
		else if (k == cpuPkg::kindJ || k == cpuPkg::kindJal)
			checkWord("jump target", target, {pc[31:28], instr[25:0], 2'b00});
		else if (k == cpuPkg::kindJr)
			checkWord("jr target", target, vRs);
		// Next ID/EX contents
		if (accept)
		begin
			mExValid = 1'b1;
			mExKind = k;
			mExRs = aRs;
			mExRt = aRt;
			mExDest = d;
			mExShamt = (k == cpuPkg::kindSll) ? instr[10:6] : 5'd0;
			mExImm = imm;
			mExRsData = (k == cpuPkg::kindSll) ? {27'd0, instr[10:6]} : vRs;
			mExRtData = vRt;
			mExResult = (k == cpuPkg::kindLui) ? {instr[15:0], 16'd0} :
				(k == cpuPkg::kindJal) ? pc + 32'd8 : 32'd0;
			mExPc = pc;
			mExTnew = tn;
		end
		else
			setBubble();
		if (wbAddr != 5'd0)
			mRegs[wbAddr] = wbData; // Lands at the coming edge
		holdInstr = instrValid && stallExp;
	endtask

	//////////////////////////////
	// Main sequence
	initial
	begin
		rst = 1'b1;
		instr = {`OP_ORI, 5'd1, 5'd2, 16'h1234}; // Valid work offered during reset
		pc = `RESET_PC + 32'h100;
		instrValid = 1'b1;
		wbAddr = 5'd0;
		wbData = 32'd0;
		memDest = 5'd0;
		memTnew = 3'd0;
		memResult = 32'd0;
		holdInstr = 1'b0;
		for (int i = 0; i < 32; i++)
			mRegs[i] = 32'd0;
		setBubble();
		repeat (resetCycles) @(posedge clk);
		rst <= 1'b0;
		instrValid <= 1'b0;
		@(negedge clk);
		checkBit("exValid after reset", exValid, 1'b0);
		checkWord("exPc after reset", exPc, `RESET_PC);
		checkBit("branchTaken after reset", branchTaken, 1'b0);
		checkBit("jumpTaken after reset", jumpTaken, 1'b0);
		for (int t = 0; t < numTests; t++)
		begin
			@(posedge clk);
			driveRandom();
			@(negedge clk); // Outputs settled mid-cycle
			evaluateCycle();
		end
		$display("Everything OK");
		$finish;
	end

endmodule

// ==== src.f ====
+incdir+.
cpuPkg.sv
instrDecoder.sv
regFile.sv
hazardUnit.sv
decodeStage.sv
decodeTop.sv
decodeTb.sv
